// File: compile.f
+incdir+hw
hw/line_window_pkg.sv
hw/line_buffer.sv
hw/window_prep.sv
hw/column_adder.sv
hw/column_scale.sv
hw/column_filter_top.sv
sim/tb_column_filter.sv

// File: sim/tb_column_filter.sv
`default_nettype none
`timescale 1ns/10ps

`include "line_window_settings.svh"

module tb_column_filter
    import line_window_pkg::*;
();

    localparam int D        = `LW_LINE_DEPTH;
    localparam int FLUSH    = `LW_ROWS * D + 10;   // Long enough to fill every line buffer
    localparam int PIPE     = 6;                   // Column to pixel_o
    localparam int HIST_LEN = 4096;

    // Cycles of all tests together including the resets
    localparam int RUN_LEN = 5 + 200 + 2 * FLUSH + (2 * FLUSH + 1) + 400
                           + (2 * FLUSH + 26) + (100 + 5 + 400);
    localparam int TIMEOUT = RUN_LEN + 200;

    logic   clk;
    logic   rst;
    pixel_t data_i;
    logic   done_i;
    pixel_t pixel_o;
    logic   done_o;

    pixel_t pix_hist  [HIST_LEN];
    logic   done_hist [HIST_LEN];
    int     cyc;                 // Index of the next driven pixel since reset
    int     cycles;
    int     checks;
    int     errors;
    integer seed;

    column_filter_top #(
        .DEPTH (D)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .data_i  (data_i),
        .done_i  (done_i),
        .pixel_o (pixel_o),
        .done_o  (done_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Mean of 17 pixels one line apart as bits 23..16 of the scaled sum
    function automatic pixel_t model_pixel(input int j);
        int sum;
        int idx;
        int k;
        sum = 0;
        for (k = 0; k < `LW_ROWS; k++) begin
            idx = j - PIPE - k * D;
            if (idx >= 0) begin
                sum += pix_hist[idx];
            end
        end
        return pixel_t'((sum * `LW_RECIP) >> 16);
    endfunction

    // A pulse at t keeps the chain input high through t+D+1
    function automatic logic model_done(input int j);
        int   src;
        int   i;
        logic hit;
        src = j - (`LW_ROWS - 1) * D - PIPE;
        hit = 1'b0;
        for (i = src - D - 1; i <= src; i++) begin
            if (i >= 0 && done_hist[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic check_pixel(input pixel_t exp);
        checks++;
        assert (pixel_o === exp) else begin
            $display("Mismatch pixel_o at cycle %0d: expected 0x%02h, got 0x%02h",
                     cyc, exp, pixel_o);
            errors++;
        end
    endtask

    task automatic check_done(input logic exp);
        checks++;
        assert (done_o === exp) else begin
            $display("Mismatch done_o at cycle %0d: expected 0x%0h, got 0x%0h",
                     cyc, exp, done_o);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        assert (act == exp) else begin
            $display("Mismatch %s: expected 0x%0h, got 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    // Check the outputs against the model and drive one pixel
    task automatic step(input pixel_t pix, input logic done);
        @(negedge clk);
        assert (cyc < HIST_LEN) else begin
            $display("History buffer overflow at cycle %0d", cyc);
            errors++;
        end
        check_pixel(model_pixel(cyc));
        check_done(model_done(cyc));
        data_i         = pix;
        done_i         = done;
        pix_hist[cyc]  = pix;
        done_hist[cyc] = done;
        cyc++;
    endtask

    task automatic apply_reset();
        rst    = 1'b1;
        data_i = '0;
        done_i = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_pixel(8'h00);
            check_done(1'b0);
        end
        rst = 1'b0;
        cyc = 0;   // History restarts so earlier pixels count as zero
    endtask

    task automatic reset_state_test();
        repeat (200) begin
            step(8'h00, 1'b0);
            check_pixel(8'h00);
            check_done(1'b0);
        end
    endtask

    task automatic flat_field_test(input pixel_t v);
        pixel_t exp;
        exp = pixel_t'((`LW_ROWS * v * `LW_RECIP) >> 16);
        repeat (FLUSH) begin
            step(v, 1'b0);
        end
        check_pixel(exp);
    endtask

    task automatic impulse_test();
        int     at;
        int     obs;
        int     hits;
        pixel_t peak;
        peak = pixel_t'((255 * `LW_RECIP) >> 16);
        hits = 0;
        repeat (FLUSH) begin
            step(8'h00, 1'b0);
        end
        at = cyc;
        step(8'hFF, 1'b0);
        repeat (FLUSH) begin
            step(8'h00, 1'b0);
            obs = cyc - 1;
            if (obs >= at + PIPE && (obs - at - PIPE) % D == 0
                && (obs - at - PIPE) / D < `LW_ROWS) begin
                check_pixel(peak);
                if (pixel_o === peak) begin
                    hits++;
                end
            end else begin
                check_pixel(8'h00);
            end
        end
        check_count("pixel_o impulse hits", `LW_ROWS, hits);
    endtask

    task automatic random_stream_test(input int n);
        repeat (n) begin
            step(pixel_t'($random(seed)), 1'b0);
        end
    endtask

    // Run n cycles of random pixels and record where done_o is high
    task automatic watch_done(input int n, output int first, output int last,
                              output int hits);
        first = -1;
        last  = -1;
        hits  = 0;
        repeat (n) begin
            step(pixel_t'($random(seed)), 1'b0);
            if (done_o === 1'b1) begin
                if (hits == 0) begin
                    first = cyc - 1;
                end
                last = cyc - 1;
                hits++;
            end
        end
    endtask

    task automatic frame_end_test();
        int t1;
        int t2;
        int t3;
        int first;
        int last;
        int hits;
        t1 = cyc;
        step(pixel_t'($random(seed)), 1'b1);
        watch_done(FLUSH + 10, first, last, hits);
        check_count("done_o first cycle", t1 + 16 * D + PIPE, first);
        check_count("done_o last cycle", t1 + 17 * D + PIPE + 1, last);
        check_count("done_o high cycles", D + 2, hits);

        // Second pulse lands inside the extension and pushes the end out
        t2 = cyc;
        step(pixel_t'($random(seed)), 1'b1);
        repeat (3) begin
            step(pixel_t'($random(seed)), 1'b0);
        end
        t3 = cyc;
        step(pixel_t'($random(seed)), 1'b1);
        watch_done(FLUSH + 10, first, last, hits);
        check_count("done_o first cycle", t2 + 16 * D + PIPE, first);
        check_count("done_o last cycle", t3 + 17 * D + PIPE + 1, last);
        check_count("done_o high cycles", t3 - t2 + D + 2, hits);
    endtask

    task automatic mid_reset_test();
        random_stream_test(100);
        apply_reset();
        random_stream_test(400);
    endtask

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        data_i = '0;
        done_i = 1'b0;
        seed   = 40;
        cyc    = 0;
        cycles = 0;
        checks = 0;
        errors = 0;

        apply_reset();
        reset_state_test();
        flat_field_test(8'h80);
        flat_field_test(8'hFF);
        impulse_test();
        random_stream_test(400);
        frame_end_test();
        mid_reset_test();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/column_filter_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "line_window_settings.svh"

module column_filter_top
    import line_window_pkg::*;
#(
    parameter int DEPTH = `LW_LINE_DEPTH
) (
    input  wire    clk,
    input  wire    rst,
    input  pixel_t data_i,
    input  wire    done_i,
    output pixel_t pixel_o,
    output logic   done_o
);

    tap_array_t taps;
    logic       taps_done;
    col_sum_t   col_sum;
    logic       sum_done;

    // Line buffers forming the 17-row column
    window_prep #(
        .DEPTH (DEPTH)
    ) u_window_prep (
        .clk    (clk),
        .rst    (rst),
        .data_i (data_i),
        .done_i (done_i),
        .taps_o (taps),
        .done_o (taps_done)
    );

    // Five cycles of adder tree
    column_adder u_column_adder (
        .clk    (clk),
        .rst    (rst),
        .taps_i (taps),
        .done_i (taps_done),
        .sum_o  (col_sum),
        .done_o (sum_done)
    );

    column_scale u_column_scale (
        .clk     (clk),
        .rst     (rst),
        .sum_i   (col_sum),
        .done_i  (sum_done),
        .pixel_o (pixel_o),
        .done_o  (done_o)
    );

endmodule

`default_nettype wire

// File: hw/column_scale.sv
`default_nettype none
`timescale 1ns/10ps

`include "line_window_settings.svh"

module column_scale
    import line_window_pkg::*;
(
    input  wire      clk,
    input  wire      rst,
    input  col_sum_t sum_i,
    input  wire      done_i,
    output pixel_t   pixel_o,
    output logic     done_o
);

    localparam int RECIP_W = $clog2(`LW_RECIP + 1);
    localparam int PROD_W  = `LW_SUM_W + RECIP_W;
    localparam int SHIFT   = 16;
    localparam int OUT_HI  = SHIFT + `LW_PIX_W - 1;

    localparam logic [RECIP_W-1:0] RECIP = RECIP_W'(`LW_RECIP);

    logic [PROD_W-1:0] product;
    pixel_t            pixel_q;
    logic              done_q;

    // Multiply by 1/17 in fixed point and take the integer byte
    assign product = sum_i * RECIP;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_q <= '0;
            done_q  <= 1'b0;
        end else begin
            pixel_q <= product[OUT_HI:SHIFT];
            done_q  <= done_i;
        end
    end

    assign pixel_o = pixel_q;
    assign done_o  = done_q;

    // Holds only while the incoming sum stays within one column of full pixels
    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst)
        product[PROD_W-1:OUT_HI+1] == '0
    );

endmodule

`default_nettype wire

// File: hw/column_adder.sv
`default_nettype none
`timescale 1ns/10ps

`include "line_window_settings.svh"

module column_adder
    import line_window_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  tap_array_t taps_i,
    input  wire        done_i,
    output col_sum_t   sum_o,
    output logic       done_o
);

    // Operand count at each level of the tree
    localparam int N0 = `LW_ROWS;
    localparam int N1 = (N0 + 1) / 2;
    localparam int N2 = (N1 + 1) / 2;
    localparam int N3 = (N2 + 1) / 2;
    localparam int N4 = (N3 + 1) / 2;
    localparam int LEVELS = 5;

    localparam col_sum_t MAX_SUM = col_sum_t'(`LW_ROWS * ((1 << `LW_PIX_W) - 1));

    col_sum_t lvl1 [N1];
    col_sum_t lvl2 [N2];
    col_sum_t lvl3 [N3];
    col_sum_t lvl4 [N4];
    col_sum_t sum_q;

    logic [LEVELS-1:0] done_sr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < N1; i++) begin
                lvl1[i] <= '0;
            end
            for (int i = 0; i < N2; i++) begin
                lvl2[i] <= '0;
            end
            for (int i = 0; i < N3; i++) begin
                lvl3[i] <= '0;
            end
            for (int i = 0; i < N4; i++) begin
                lvl4[i] <= '0;
            end
            sum_q <= '0;
        end else begin
            // Widen the pixels on the way into the first level
            for (int i = 0; i < N1; i++) begin
                if (2 * i + 1 < N0) begin
                    lvl1[i] <= col_sum_t'(taps_i[2*i]) + col_sum_t'(taps_i[2*i+1]);
                end else begin
                    lvl1[i] <= col_sum_t'(taps_i[2*i]);   // Odd tap passes through
                end
            end
            for (int i = 0; i < N2; i++) begin
                if (2 * i + 1 < N1) begin
                    lvl2[i] <= lvl1[2*i] + lvl1[2*i+1];
                end else begin
                    lvl2[i] <= lvl1[2*i];
                end
            end
            for (int i = 0; i < N3; i++) begin
                if (2 * i + 1 < N2) begin
                    lvl3[i] <= lvl2[2*i] + lvl2[2*i+1];
                end else begin
                    lvl3[i] <= lvl2[2*i];
                end
            end
            for (int i = 0; i < N4; i++) begin
                if (2 * i + 1 < N3) begin
                    lvl4[i] <= lvl3[2*i] + lvl3[2*i+1];
                end else begin
                    lvl4[i] <= lvl3[2*i];
                end
            end
            sum_q <= lvl4[0] + lvl4[1];
        end
    end

    // Done rides alongside the tree
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_sr <= '0;
        end else begin
            done_sr <= {done_sr[LEVELS-2:0], done_i};
        end
    end

    assign sum_o  = sum_q;
    assign done_o = done_sr[LEVELS-1];

    // A larger sum means the tree dropped or doubled an operand
    a_sum_range : assert property (
        @(posedge clk) disable iff (rst)
        sum_o <= MAX_SUM
    );

endmodule

`default_nettype wire

// File: hw/window_prep.sv
`default_nettype none
`timescale 1ns/10ps

`include "line_window_settings.svh"

module window_prep
    import line_window_pkg::*;
#(
    parameter int DEPTH = `LW_LINE_DEPTH
) (
    input  wire        clk,
    input  wire        rst,
    input  pixel_t     data_i,
    input  wire        done_i,
    output tap_array_t taps_o,
    output logic       done_o
);

    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int N_LINES = `LW_ROWS - 1;

    logic [CNT_W-1:0] ext_cnt;
    logic             done_ext;
    logic             chain_done_in;

    tap_array_t       chain_data;
    logic [N_LINES:0] chain_done;

    // Stretch done so it covers the flush of a full line plus one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ext_cnt  <= '0;
            done_ext <= 1'b0;
        end else if (done_i) begin
            ext_cnt  <= '0;            // Restart on a new pulse
            done_ext <= 1'b1;
        end else if (done_ext && ext_cnt < DEPTH) begin
            ext_cnt  <= ext_cnt + 1'b1;
            done_ext <= 1'b1;
        end else begin
            ext_cnt  <= '0;
            done_ext <= 1'b0;
        end
    end

    assign chain_done_in = done_i | done_ext;

    // Head of the chain is the live pixel
    assign chain_data[0] = data_i;
    assign chain_done[0] = chain_done_in;

    for (genvar i = 0; i < N_LINES; i++) begin : gen_lines
        line_buffer #(
            .DEPTH (DEPTH)
        ) u_line_buffer (
            .clk    (clk),
            .rst    (rst),
            .data_i (chain_data[i]),
            .done_i (chain_done[i]),
            .data_o (chain_data[i+1]),
            .done_o (chain_done[i+1])
        );
    end

    assign taps_o = chain_data;
    assign done_o = chain_done[N_LINES];   // Last line flushed

    a_cnt_bound : assert property (
        @(posedge clk) disable iff (rst)
        ext_cnt <= CNT_W'(DEPTH)
    );

endmodule

`default_nettype wire

// File: hw/line_buffer.sv
`default_nettype none
`timescale 1ns/10ps

`include "line_window_settings.svh"

module line_buffer
    import line_window_pkg::*;
#(
    parameter int DEPTH = `LW_LINE_DEPTH
) (
    input  wire    clk,
    input  wire    rst,
    input  pixel_t data_i,
    input  wire    done_i,
    output pixel_t data_o,
    output logic   done_o
);

    pixel_t             data_sr [DEPTH];
    logic   [DEPTH-1:0] done_sr;

    // One line of delay with the done flag travelling beside the pixels
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                data_sr[i] <= '0;
            end
            done_sr <= '0;
        end else begin
            data_sr[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                data_sr[i] <= data_sr[i-1];
            end
            done_sr <= {done_sr[DEPTH-2:0], done_i};
        end
    end

    assign data_o = data_sr[DEPTH-1];
    assign done_o = done_sr[DEPTH-1];

    // An X on done here would spread down the chain to done_o at the top
    a_done_known : assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(done_o)
    );

endmodule

`default_nettype wire

// File: hw/line_window_pkg.sv
`default_nettype none

`include "line_window_settings.svh"

package line_window_pkg;

    // One pixel of the raster stream
    typedef logic [`LW_PIX_W-1:0] pixel_t;

    // Sum over one full column
    typedef logic [`LW_SUM_W-1:0] col_sum_t;

    // Column taps where index k is the pixel k lines back
    typedef pixel_t tap_array_t [`LW_ROWS];

endpackage

`default_nettype wire

// File: hw/line_window_settings.svh
`ifndef LINE_WINDOW_SETTINGS_SVH
`define LINE_WINDOW_SETTINGS_SVH

// Pixel width in bits
`define LW_PIX_W 8

// Pixels per line in a deliberately short frame
`define LW_LINE_DEPTH 8

// Current line plus sixteen buffered lines make one column
`define LW_ROWS 17

// Reciprocal of the row count in 16-bit fixed point (65536/17)
`define LW_RECIP 3855

// Column sum width that holds 17 * 255
`define LW_SUM_W 13

`endif
